// File: src.f
+incdir+design
design/timerPkg.sv
design/cmdCapture.sv
design/cmdArbiter.sv
design/clockBank.sv
design/alarmBank.sv
design/timerTop.sv
dv/timerTb.sv

// File: dv/timerTb.sv
//////////////////////////////////////////////////////////////////////
// timer block testbench
// drives instruction pairs into timerTop and checks stat and alarmHit
// against per-edge expectations built from the block's timing rules
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "timer_cfg.svh"

module timerTb;

  localparam int numTests   = 6;
  localparam int testBudget = 300;                          // cycles, longest test well below
  localparam int wdCycles   = numTests * testBudget + 700;
  localparam int planLen    = wdCycles + 16;

  logic                       clk_1x;
  logic                       reset;
  logic                       req;
  logic [`TMR_HALF_W-1:0]     ctrlA;
  logic [`TMR_HALF_W-1:0]     ctrlB;
  logic [1:0]                 stat;
  logic [`TMR_NUM_ALARMS-1:0] alarmHit;

  // expected values, index = edges since reset release
  logic [1:0]                 statPlan [0:planLen-1];
  logic [`TMR_NUM_ALARMS-1:0] hitPlan  [0:planLen-1];
  logic [1:0]                 expStat;
  logic [`TMR_NUM_ALARMS-1:0] expHit;
  logic [`TMR_NUM_ALARMS-1:0] careMask;                     // slots with exact timing known

  int                         cyc;
  int                         seed;
  int                         errCount;
  int                         errMark;
  int                         passCount;
  int                         failCount;
  logic [`TMR_NUM_ALARMS-1:0] slotUsed;
  logic [`TMR_NUM_CLOCKS-1:0] clockUsed;
  timerPkg::clkIdxT           cFull;                        // rateFull clock shared by tests

  timerTop u_dut (
    .clk_1x   (clk_1x),
    .reset    (reset),
    .req      (req),
    .ctrlA    (ctrlA),
    .ctrlB    (ctrlB),
    .stat     (stat),
    .alarmHit (alarmHit)
  );

  initial begin
    clk_1x = 1'b0;
    forever #10 clk_1x = ~clk_1x;
  end

  // edge counter and registered expectations
  always @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      cyc     <= 0;
      expStat <= '0;
      expHit  <= '0;
    end else begin
      cyc     <= cyc + 1;
      expStat <= statPlan[cyc + 1];
      expHit  <= hitPlan[cyc + 1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////
  statCheck: assert property (@(posedge clk_1x) disable iff (reset) stat == expStat)
    else begin
      errCount++;
      $display("FAILED stat: got %h expected %h at edge %0d",
               $sampled(stat), $sampled(expStat), $sampled(cyc));
    end

  hitCheck: assert property (@(posedge clk_1x) disable iff (reset)
                             (alarmHit & careMask) == (expHit & careMask))
    else begin
      errCount++;
      $display("FAILED alarmHit: got %h expected %h at edge %0d",
               $sampled(alarmHit & careMask), $sampled(expHit & careMask), $sampled(cyc));
    end

  //////////////////////////////////////////////////////////////////////
  // word builders and helpers
  //////////////////////////////////////////////////////////////////////
  function automatic timerPkg::cmdWordT setClockWord(timerPkg::clkIdxT clk,
                                                     timerPkg::rateT rate,
                                                     timerPkg::countT value);
    timerPkg::cmdWordT w;
    w                = '0;
    w[`TMR_F_OPCODE] = timerPkg::opSetClock;
    w[`TMR_F_CLOCK]  = clk;
    w[`TMR_F_RATE]   = rate;
    w[`TMR_F_VALUE]  = value;
    return w;
  endfunction

  function automatic timerPkg::cmdWordT enClockWord(timerPkg::clkIdxT clk, logic en);
    timerPkg::cmdWordT w;
    w                = '0;
    w[`TMR_F_OPCODE] = timerPkg::opEnClock;
    w[`TMR_F_CLOCK]  = clk;
    w[`TMR_F_ENABLE] = en;
    return w;
  endfunction

  // set alarm, set timer, enable alarm, or a bad opcode
  function automatic timerPkg::cmdWordT alarmWord(logic [2:0] op, timerPkg::almIdxT slot,
                                                  logic en, timerPkg::clkIdxT asg,
                                                  timerPkg::countT value);
    timerPkg::cmdWordT w;
    w                = '0;
    w[`TMR_F_OPCODE] = op;
    w[`TMR_F_ALARM]  = slot;
    w[`TMR_F_ENABLE] = en;                                  // repeat for set alarm
    w[`TMR_F_ASSIGN] = asg;
    w[`TMR_F_VALUE]  = value;
    return w;
  endfunction

  function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic timerPkg::almIdxT pickSlot();
    int s;
    s = randBelow(`TMR_NUM_ALARMS);
    while (slotUsed[s]) s = (s + 1) % `TMR_NUM_ALARMS;       // next free slot
    slotUsed[s] = 1'b1;
    return timerPkg::almIdxT'(s);
  endfunction

  function automatic timerPkg::clkIdxT pickClock();
    int c;
    c = randBelow(`TMR_NUM_CLOCKS);
    while (clockUsed[c]) c = (c + 1) % `TMR_NUM_CLOCKS;
    clockUsed[c] = 1'b1;
    return timerPkg::clkIdxT'(c);
  endfunction

  task automatic waitCycles(int n);
    repeat (n) @(posedge clk_1x);
  endtask

  // upper halves after edge e, lower halves after e+1, result lands at e+2
  task automatic sendPair(input timerPkg::cmdWordT a, input timerPkg::cmdWordT b,
                          input logic [1:0] expSt, output int applyEdge);
    int e;
    @(posedge clk_1x);
    e = cyc + 1;                                            // counter not yet updated here
    req   <= 1'b1;
    ctrlA <= a[2*`TMR_HALF_W-1 -: `TMR_HALF_W];
    ctrlB <= b[2*`TMR_HALF_W-1 -: `TMR_HALF_W];
    @(posedge clk_1x);
    req   <= 1'b0;
    ctrlA <= a[`TMR_HALF_W-1:0];
    ctrlB <= b[`TMR_HALF_W-1:0];
    applyEdge = e + 2;
    statPlan[applyEdge] = expSt;                            // one cycle of status
  endtask

  // hit shows from the fire edge for the hold length
  task automatic expectHit(timerPkg::almIdxT slot, int fireEdge);
    for (int h = 0; h < `TMR_HOLD_CYCLES; h++) hitPlan[fireEdge + h][slot] = 1'b1;
  endtask

  task automatic reportTest(string name, int errBefore);
    if (errCount == errBefore) begin
      passCount++;
      $display("test %-18s ok", name);
    end else begin
      failCount++;
      $display("test %-18s failed, %0d errors", name, errCount - errBefore);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////
  task automatic resetStatus();
    int a;
    waitCycles(4);                                          // idle, stat and hits stay 0
    cFull = pickClock();
    sendPair(setClockWord(cFull, timerPkg::rateFull, '0), '0, 2'b01, a);
    waitCycles(3);
    sendPair('0, enClockWord(cFull, 1'b1), 2'b10, a);       // B alone
    waitCycles(4);
  endtask

  task automatic countdownHold();
    timerPkg::clkIdxT cRun;
    timerPkg::almIdxT sA;
    timerPkg::almIdxT sB;
    int               kA;
    int               kB;
    int               a;
    cRun = pickClock();
    sA   = pickSlot();
    sB   = pickSlot();
    kA   = 2 + randBelow(8);
    kB   = 2 + randBelow(8);
    sendPair(setClockWord(cRun, timerPkg::rateFull, '0), '0, 2'b01, a);
    sendPair(alarmWord(timerPkg::opSetTimer, sA, 1'b0, cRun, timerPkg::countT'(kA)),
             alarmWord(timerPkg::opSetTimer, sB, 1'b0, cRun, timerPkg::countT'(kB)),
             2'b11, a);
    expectHit(sA, a + kA - 1);                              // fires at edge N+k
    expectHit(sB, a + kB - 1);
    waitCycles(12);
    // clock back below both targets, one-shot timers stay quiet
    sendPair(setClockWord(cRun, timerPkg::rateFull, '0), '0, 2'b01, a);
    waitCycles(14);
  endtask

  task automatic conflictNack();
    timerPkg::clkIdxT cIdle;
    timerPkg::almIdxT sProbe;
    timerPkg::almIdxT sConf;
    timerPkg::almIdxT sGood;
    timerPkg::almIdxT sGood2;
    int               k;
    int               k2;
    int               a;
    cIdle  = pickClock();
    sProbe = pickSlot();
    sConf  = pickSlot();
    sGood  = pickSlot();
    sGood2 = pickSlot();
    // same clock from both clients, clock must stay stopped
    sendPair(setClockWord(cIdle, timerPkg::rateFull, '0),
             setClockWord(cIdle, timerPkg::rateHalf, 16'h0010), 2'b00, a);
    sendPair(alarmWord(timerPkg::opSetTimer, sProbe, 1'b0, cIdle, 16'd2), '0, 2'b01, a);
    waitCycles(6);
    sendPair(alarmWord(timerPkg::opEnAlarm, sProbe, 1'b0, cIdle, '0), '0, 2'b01, a);
    // same alarm, set timer against set alarm
    sendPair(alarmWord(timerPkg::opSetTimer, sConf, 1'b0, cFull, 16'd3),
             alarmWord(timerPkg::opSetAlarm, sConf, 1'b1, cFull, timerPkg::countT'($random(seed))),
             2'b00, a);
    waitCycles(6);
    // bad field on one side only
    k  = 2 + randBelow(6);
    k2 = 2 + randBelow(6);
    sendPair(alarmWord(3'b011, sGood, 1'b0, cFull, 16'd2),
             setClockWord(cIdle, timerPkg::rateFull, '0), 2'b10, a);
    sendPair(alarmWord(timerPkg::opSetTimer, sGood, 1'b0, cIdle, timerPkg::countT'(k)),
             alarmWord(3'b100, sGood2, 1'b0, cFull, 16'd2), 2'b01, a);
    expectHit(sGood, a + k - 1);
    sendPair(alarmWord(timerPkg::opSetAlarm, timerPkg::almIdxT'(24 + randBelow(8)), 1'b0,
                       cFull, 16'd5),
             alarmWord(timerPkg::opSetTimer, sGood2, 1'b0, cFull, timerPkg::countT'(k2)),
             2'b10, a);
    expectHit(sGood2, a + k2 - 1);
    waitCycles(14);
  endtask

  task automatic absoluteRepeat();
    timerPkg::clkIdxT cAbs;
    timerPkg::almIdxT sRep;
    timerPkg::almIdxT sOne;
    int               v;
    int               a0;
    int               a;
    cAbs = pickClock();
    sRep = pickSlot();
    sOne = pickSlot();
    v    = 20 + randBelow(16);
    sendPair(setClockWord(cAbs, timerPkg::rateFull, '0), '0, 2'b01, a0);
    sendPair(alarmWord(timerPkg::opSetAlarm, sRep, 1'b1, cAbs, timerPkg::countT'(v)),
             alarmWord(timerPkg::opSetAlarm, sOne, 1'b0, cAbs, timerPkg::countT'(v + 3)),
             2'b11, a);
    expectHit(sRep, a0 + v);                                // count after edge a0+j is j
    expectHit(sOne, a0 + v + 3);
    waitCycles(v + 6);
    // reload below both values, only the repeating one returns
    sendPair(setClockWord(cAbs, timerPkg::rateFull, '0), '0, 2'b01, a);
    expectHit(sRep, a + v);
    waitCycles(v + 8);
  endtask

  task automatic disablePending();
    timerPkg::clkIdxT cStop;
    timerPkg::almIdxT sOff;
    timerPkg::almIdxT sHeld;
    int               k;
    int               left;
    int               tSet;
    int               tStop;
    int               a;
    sOff  = pickSlot();
    sHeld = pickSlot();
    cStop = pickClock();
    // alarm disarmed before it fires
    k = 6 + randBelow(4);
    sendPair(alarmWord(timerPkg::opSetTimer, sOff, 1'b0, cFull, timerPkg::countT'(k)), '0,
             2'b01, a);
    sendPair(alarmWord(timerPkg::opEnAlarm, sOff, 1'b0, cFull, '0), '0, 2'b01, a);
    waitCycles(k + 4);
    // clock stopped under a pending timer
    k = 8 + randBelow(4);
    sendPair(setClockWord(cStop, timerPkg::rateFull, '0), '0, 2'b01, a);
    sendPair('0, alarmWord(timerPkg::opSetTimer, sHeld, 1'b0, cStop, timerPkg::countT'(k)),
             2'b10, tSet);
    sendPair(enClockWord(cStop, 1'b0), '0, 2'b01, tStop);
    waitCycles(2 * k);
    left = k - (tStop - tSet);                              // ticks at tSet..tStop-1 already done
    sendPair(enClockWord(cStop, 1'b1), '0, 2'b01, a);
    expectHit(sHeld, a + left);                             // no tick on the enable edge
    waitCycles(left + 6);
  endtask

  task automatic rateOrder();
    timerPkg::clkIdxT cQuarter;
    timerPkg::almIdxT sFull;
    timerPkg::almIdxT sQuarter;
    int               k;
    int               a;
    int               n;
    int               qEdge;
    cQuarter = pickClock();
    sFull    = pickSlot();
    sQuarter = pickSlot();
    k        = 3 + randBelow(4);
    sendPair(setClockWord(cQuarter, timerPkg::rateQuarter, '0), '0, 2'b01, a);
    careMask[sQuarter] = 1'b0;                              // prescaler phase not pinned down
    sendPair(alarmWord(timerPkg::opSetTimer, sFull, 1'b0, cFull, timerPkg::countT'(k)),
             alarmWord(timerPkg::opSetTimer, sQuarter, 1'b0, cQuarter, timerPkg::countT'(k)),
             2'b11, a);
    expectHit(sFull, a + k - 1);
    qEdge = -1;
    n     = 0;
    while (n < 4 * k + 8 && qEdge < 0) begin
      @(negedge clk_1x);                                    // outputs settled
      if (alarmHit[sQuarter]) qEdge = cyc;
      n++;
    end
    if (qEdge < 0) begin
      errCount++;
      $display("quarter-rate timer never fired within %0d cycles", 4 * k + 8);
    end else begin
      quarterAfterFull: assert (qEdge > a + k - 1)
        else begin
          errCount++;
          $display("quarter-rate timer fired at edge %0d, not after the full-rate one", qEdge);
        end
      quarterInWindow: assert (qEdge - a <= 4 * k + 4)
        else begin
          errCount++;
          $display("quarter-rate timer fired %0d cycles after its ack", qEdge - a);
        end
    end
    waitCycles(4);
    careMask[sQuarter] = 1'b1;                              // must stay quiet from here
    waitCycles(8);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin
    reset     = 1'b1;
    req       = 1'b0;
    ctrlA     = '0;
    ctrlB     = '0;
    seed      = 61;
    errCount  = 0;
    passCount = 0;
    failCount = 0;
    careMask  = '1;
    slotUsed  = '0;
    clockUsed = '0;
    for (int i = 0; i < planLen; i++) begin
      statPlan[i] = '0;
      hitPlan[i]  = '0;
    end
    repeat (3) @(posedge clk_1x);
    reset <= 1'b0;

    errMark = errCount;
    resetStatus();
    reportTest("reset and status", errMark);
    errMark = errCount;
    countdownHold();
    reportTest("countdown", errMark);
    errMark = errCount;
    conflictNack();
    reportTest("conflicts", errMark);
    errMark = errCount;
    absoluteRepeat();
    reportTest("absolute alarm", errMark);
    errMark = errCount;
    disablePending();
    reportTest("disabling", errMark);
    errMark = errCount;
    rateOrder();
    reportTest("rates", errMark);

    $display("tests passed %0d, failed %0d, check errors %0d", passCount, failCount, errCount);
    if (failCount == 0 && errCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    repeat (wdCycles) @(posedge clk_1x);
    $display("watchdog expired after %0d cycles, tests did not finish", wdCycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: design/timerTop.sv
//////////////////////////////////////////////////////////////////////
// timer block top
// two command captures, the arbiter, clock bank and alarm bank
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "timer_cfg.svh"

module timerTop (
  input  logic                       clk_1x,
  input  logic                       reset,
  input  logic                       req,
  input  logic [`TMR_HALF_W-1:0]     ctrlA,
  input  logic [`TMR_HALF_W-1:0]     ctrlB,
  output logic [1:0]                 stat,
  output logic [`TMR_NUM_ALARMS-1:0] alarmHit
);

  // capture to arbiter and banks
  logic                                  validA;
  logic                                  validB;
  timerPkg::cmdWordT                     wordA;
  timerPkg::cmdWordT                     wordB;

  // arbiter strobes
  logic                                  clkWrA;
  logic                                  clkWrB;
  logic                                  clkEnOnlyA;
  logic                                  clkEnOnlyB;
  logic                                  almWrA;
  logic                                  almWrB;
  logic                                  almTimerA;
  logic                                  almTimerB;
  logic                                  almEnOnlyA;
  logic                                  almEnOnlyB;

  // clock bank to alarm bank
  timerPkg::countT [`TMR_NUM_CLOCKS-1:0] counts;
  logic [`TMR_NUM_CLOCKS-1:0]            clkTick;

  //////////////////////////////////////////////////////////////////////
  // instruction path
  //////////////////////////////////////////////////////////////////////
  cmdCapture u_capA (
    .clk_1x   (clk_1x),
    .reset    (reset),
    .req      (req),
    .ctrl     (ctrlA),
    .cmdValid (validA),
    .cmdWord  (wordA)
  );

  cmdCapture u_capB (
    .clk_1x   (clk_1x),
    .reset    (reset),
    .req      (req),
    .ctrl     (ctrlB),
    .cmdValid (validB),
    .cmdWord  (wordB)
  );

  cmdArbiter u_arbiter (
    .clk_1x     (clk_1x),
    .reset      (reset),
    .validA     (validA),
    .validB     (validB),
    .wordA      (wordA),
    .wordB      (wordB),
    .clkWrA     (clkWrA),
    .clkWrB     (clkWrB),
    .clkEnOnlyA (clkEnOnlyA),
    .clkEnOnlyB (clkEnOnlyB),
    .almWrA     (almWrA),
    .almWrB     (almWrB),
    .almTimerA  (almTimerA),
    .almTimerB  (almTimerB),
    .almEnOnlyA (almEnOnlyA),
    .almEnOnlyB (almEnOnlyB),
    .stat       (stat)
  );

  //////////////////////////////////////////////////////////////////////
  // clocks and alarms
  //////////////////////////////////////////////////////////////////////
  clockBank u_clockBank (
    .clk_1x     (clk_1x),
    .reset      (reset),
    .clkWrA     (clkWrA),
    .clkWrB     (clkWrB),
    .clkEnOnlyA (clkEnOnlyA),
    .clkEnOnlyB (clkEnOnlyB),
    .wordA      (wordA),
    .wordB      (wordB),
    .counts     (counts),
    .clkTick    (clkTick)
  );

  alarmBank u_alarmBank (
    .clk_1x     (clk_1x),
    .reset      (reset),
    .almWrA     (almWrA),
    .almWrB     (almWrB),
    .almTimerA  (almTimerA),
    .almTimerB  (almTimerB),
    .almEnOnlyA (almEnOnlyA),
    .almEnOnlyB (almEnOnlyB),
    .wordA      (wordA),
    .wordB      (wordB),
    .counts     (counts),
    .clkTick    (clkTick),
    .alarmHit   (alarmHit)
  );

endmodule

// File: design/alarmBank.sv
//////////////////////////////////////////////////////////////////////
// alarm bank
// 24 alarm / countdown slots compared against their clock's next
// count, with repeat handling and a held hit output per slot
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "timer_cfg.svh"

module alarmBank (
  input  logic                                   clk_1x,
  input  logic                                   reset,
  input  logic                                   almWrA,
  input  logic                                   almWrB,
  input  logic                                   almTimerA,
  input  logic                                   almTimerB,
  input  logic                                   almEnOnlyA,
  input  logic                                   almEnOnlyB,
  input  timerPkg::cmdWordT                      wordA,
  input  timerPkg::cmdWordT                      wordB,
  input  timerPkg::countT [`TMR_NUM_CLOCKS-1:0] counts,
  input  logic [`TMR_NUM_CLOCKS-1:0]             clkTick,
  output logic [`TMR_NUM_ALARMS-1:0]             alarmHit
);

  localparam int holdCntW = $clog2(`TMR_HOLD_CYCLES + 1);

  timerPkg::almIdxT idxA;
  timerPkg::almIdxT idxB;
  timerPkg::clkIdxT asgA;
  timerPkg::clkIdxT asgB;
  timerPkg::countT  timerValA;       // countdown target, client A
  timerPkg::countT  timerValB;

  assign idxA = wordA[`TMR_F_ALARM];
  assign idxB = wordB[`TMR_F_ALARM];
  assign asgA = wordA[`TMR_F_ASSIGN];
  assign asgB = wordB[`TMR_F_ASSIGN];

  // interval plus what the clock shows in the lower half cycle
  assign timerValA = wordA[`TMR_F_VALUE] + counts[asgA];
  assign timerValB = wordB[`TMR_F_VALUE] + counts[asgB];

  for (genvar i = 0; i < `TMR_NUM_ALARMS; i++) begin : gSlot
    logic                armed;
    logic                repeatOn;
    timerPkg::clkIdxT    clkSel;
    timerPkg::countT     value;
    logic [holdCntW-1:0] holdCnt;
    logic                selA;
    logic                selB;
    logic                wrAny;
    logic                isTimer;
    logic                enOnly;
    logic                fire;
    timerPkg::cmdWordT   selWord;
    timerPkg::countT     selTimerVal;
    timerPkg::countT     nextCount;

    assign selA        = almWrA && (idxA == timerPkg::almIdxT'(i));
    assign selB        = almWrB && (idxB == timerPkg::almIdxT'(i));
    assign wrAny       = selA || selB;
    assign selWord     = selA ? wordA : wordB;
    assign isTimer     = selA ? almTimerA : almTimerB;
    assign enOnly      = selA ? almEnOnlyA : almEnOnlyB;
    assign selTimerVal = selA ? timerValA : timerValB;

    // fires on the edge where the clock reaches the value
    assign nextCount = counts[clkSel] + 1'b1;
    assign fire      = armed && clkTick[clkSel] && (nextCount == value) && !wrAny;

    always_ff @(posedge clk_1x or posedge reset) begin
      if (reset) begin
        armed    <= 1'b0;
        repeatOn <= 1'b0;
        clkSel   <= '0;
        value    <= '0;
        holdCnt  <= '0;
      end else begin
        if (wrAny) begin
          if (enOnly) begin
            armed <= selWord[`TMR_F_ENABLE];
          end else begin               // set alarm or set timer
            armed    <= 1'b1;
            clkSel   <= selWord[`TMR_F_ASSIGN];
            value    <= isTimer ? selTimerVal : selWord[`TMR_F_VALUE];
            repeatOn <= isTimer ? 1'b0 : selWord[`TMR_F_ENABLE];   // timers one-shot
          end
        end else if (fire && !repeatOn) begin
          armed <= 1'b0;
        end

        // hit hold, restarts on a repeat fire
        if (fire) begin
          holdCnt <= holdCntW'(`TMR_HOLD_CYCLES);
        end else if (holdCnt != '0) begin
          holdCnt <= holdCnt - 1'b1;
        end
      end
    end

    assign alarmHit[i] = (holdCnt != '0);
  end

endmodule

// File: design/clockBank.sv
//////////////////////////////////////////////////////////////////////
// clock bank
// sixteen count-up clocks with enable and rate, driven from one
// free-running prescaler on clk_1x
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "timer_cfg.svh"

module clockBank (
  input  logic                                   clk_1x,
  input  logic                                   reset,
  input  logic                                   clkWrA,
  input  logic                                   clkWrB,
  input  logic                                   clkEnOnlyA,
  input  logic                                   clkEnOnlyB,
  input  timerPkg::cmdWordT                      wordA,
  input  timerPkg::cmdWordT                      wordB,
  output timerPkg::countT [`TMR_NUM_CLOCKS-1:0] counts,
  output logic [`TMR_NUM_CLOCKS-1:0]             clkTick
);

  logic [1:0]       preCnt;          // prescaler
  logic             halfStb;
  logic             quarterStb;
  timerPkg::clkIdxT idxA;
  timerPkg::clkIdxT idxB;

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      preCnt <= 2'b00;
    end else begin
      preCnt <= preCnt + 1'b1;
    end
  end

  assign halfStb    = preCnt[0];      // every second edge
  assign quarterStb = &preCnt;        // every fourth edge

  assign idxA = wordA[`TMR_F_CLOCK];
  assign idxB = wordB[`TMR_F_CLOCK];

  for (genvar i = 0; i < `TMR_NUM_CLOCKS; i++) begin : gClock
    logic              enabled;
    timerPkg::rateT    rate;
    timerPkg::countT   count;
    logic              selA;
    logic              selB;
    logic              wrAny;
    logic              enOnly;
    logic              rateStb;
    timerPkg::cmdWordT selWord;

    // arbiter never lets both clients hit the same clock
    assign selA    = clkWrA && (idxA == timerPkg::clkIdxT'(i));
    assign selB    = clkWrB && (idxB == timerPkg::clkIdxT'(i));
    assign wrAny   = selA || selB;
    assign selWord = selA ? wordA : wordB;
    assign enOnly  = selA ? clkEnOnlyA : clkEnOnlyB;

    always_comb begin
      case (rate)
        timerPkg::rateFull:    rateStb = 1'b1;
        timerPkg::rateHalf:    rateStb = halfStb;
        timerPkg::rateQuarter: rateStb = quarterStb;
        default:               rateStb = 1'b0;   // stopped
      endcase
    end

    // a write this edge beats counting, so no tick either
    assign clkTick[i] = enabled && rateStb && !wrAny;
    assign counts[i]  = count;

    always_ff @(posedge clk_1x or posedge reset) begin
      if (reset) begin
        enabled <= 1'b0;
        rate    <= timerPkg::rateFull;
        count   <= '0;
      end else if (wrAny) begin
        if (enOnly) begin
          enabled <= selWord[`TMR_F_ENABLE];
        end else begin                 // set clock loads and starts
          enabled <= 1'b1;
          rate    <= timerPkg::rateT'(selWord[`TMR_F_RATE]);
          count   <= selWord[`TMR_F_VALUE];
        end
      end else if (clkTick[i]) begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

// File: design/cmdArbiter.sv
//////////////////////////////////////////////////////////////////////
// command arbiter
// decodes both clients' commands, rejects bad fields and conflicts,
// raises the bank write strobes and registers the Ack/Nack status
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "timer_cfg.svh"

module cmdArbiter (
  input  logic              clk_1x,
  input  logic              reset,
  input  logic              validA,
  input  logic              validB,
  input  timerPkg::cmdWordT wordA,
  input  timerPkg::cmdWordT wordB,
  output logic              clkWrA,
  output logic              clkWrB,
  output logic              clkEnOnlyA,
  output logic              clkEnOnlyB,
  output logic              almWrA,
  output logic              almWrB,
  output logic              almTimerA,
  output logic              almTimerB,
  output logic              almEnOnlyA,
  output logic              almEnOnlyB,
  output logic [1:0]        stat
);

  timerPkg::opcodeT opA;
  timerPkg::opcodeT opB;
  timerPkg::clkIdxT clkIdxA;
  timerPkg::clkIdxT clkIdxB;
  timerPkg::almIdxT almIdxA;
  timerPkg::almIdxT almIdxB;
  logic             isClkA;      // valid clock command
  logic             isClkB;
  logic             isAlmA;      // valid alarm class command, index in range
  logic             isAlmB;
  logic             conflict;
  logic             acceptA;
  logic             acceptB;
  timerPkg::statusT statA;
  timerPkg::statusT statB;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////
  assign opA     = timerPkg::opcodeT'(wordA[`TMR_F_OPCODE]);
  assign opB     = timerPkg::opcodeT'(wordB[`TMR_F_OPCODE]);
  assign clkIdxA = wordA[`TMR_F_CLOCK];
  assign clkIdxB = wordB[`TMR_F_CLOCK];
  assign almIdxA = wordA[`TMR_F_ALARM];
  assign almIdxB = wordB[`TMR_F_ALARM];

  assign isClkA = validA &&
                  (opA == timerPkg::opSetClock || opA == timerPkg::opEnClock);
  assign isClkB = validB &&
                  (opB == timerPkg::opSetClock || opB == timerPkg::opEnClock);

  assign isAlmA = validA && (almIdxA < timerPkg::almIdxT'(`TMR_NUM_ALARMS)) &&
                  (opA == timerPkg::opSetAlarm || opA == timerPkg::opSetTimer ||
                   opA == timerPkg::opEnAlarm);
  assign isAlmB = validB && (almIdxB < timerPkg::almIdxT'(`TMR_NUM_ALARMS)) &&
                  (opB == timerPkg::opSetAlarm || opB == timerPkg::opSetTimer ||
                   opB == timerPkg::opEnAlarm);

  //////////////////////////////////////////////////////////////////////
  // conflict check
  //////////////////////////////////////////////////////////////////////
  // same target from both sides kills both commands
  assign conflict = (isClkA && isClkB && (clkIdxA == clkIdxB)) ||
                    (isAlmA && isAlmB && (almIdxA == almIdxB));

  assign acceptA = (isClkA || isAlmA) && !conflict;
  assign acceptB = (isClkB || isAlmB) && !conflict;

  // write strobes, land in the banks at the end of the lower half cycle
  assign clkWrA     = acceptA && isClkA;
  assign clkWrB     = acceptB && isClkB;
  assign clkEnOnlyA = clkWrA && (opA == timerPkg::opEnClock);
  assign clkEnOnlyB = clkWrB && (opB == timerPkg::opEnClock);

  assign almWrA     = acceptA && isAlmA;
  assign almWrB     = acceptB && isAlmB;
  assign almTimerA  = almWrA && (opA == timerPkg::opSetTimer);
  assign almTimerB  = almWrB && (opB == timerPkg::opSetTimer);
  assign almEnOnlyA = almWrA && (opA == timerPkg::opEnAlarm);
  assign almEnOnlyB = almWrB && (opB == timerPkg::opEnAlarm);

  //////////////////////////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////////////////////////
  assign statA = acceptA ? timerPkg::ack : timerPkg::nack;
  assign statB = acceptB ? timerPkg::ack : timerPkg::nack;

  // one cycle only, idle clients read nack
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      stat <= 2'b00;
    end else begin
      stat <= {statB, statA};           // B in bit 1
    end
  end

endmodule

// File: design/cmdCapture.sv
//////////////////////////////////////////////////////////////////////
// command capture
// joins one client's two 16-bit halves into a 32-bit command
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "timer_cfg.svh"

module cmdCapture (
  input  logic                   clk_1x,
  input  logic                   reset,
  input  logic                   req,
  input  logic [`TMR_HALF_W-1:0] ctrl,
  output logic                   cmdValid,
  output timerPkg::cmdWordT      cmdWord
);

  logic                   pending;     // upper half held, lower half due now
  logic [`TMR_HALF_W-1:0] upperHalf;
  logic                   startCmd;
  timerPkg::opcodeT       halfOp;

  // opcode sits in the top bits of the upper half
  assign halfOp = timerPkg::opcodeT'(ctrl[`TMR_HALF_W-1 -: $bits(timerPkg::opcodeT)]);

  // nop upper halves are ignored, so is anything while pending
  assign startCmd = req && !pending && (halfOp != timerPkg::opNop);

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (pending) begin
      pending <= 1'b0;                  // lower half taken this cycle
    end else if (startCmd) begin
      pending <= 1'b1;
    end
  end

  // upper half held until the lower half arrives
  always_ff @(posedge clk_1x) begin
    if (startCmd) begin
      upperHalf <= ctrl;
    end
  end

  // lower half goes straight through, no extra cycle
  assign cmdValid = pending;
  assign cmdWord  = {upperHalf, ctrl};

endmodule

// File: design/timerPkg.sv
//////////////////////////////////////////////////////////////////////
// timer package
// opcode, rate, status and index types shared by the timer block
//////////////////////////////////////////////////////////////////////
`include "timer_cfg.svh"

package timerPkg;

  // instruction opcodes, 011 and 100 left out on purpose -> invalid
  typedef enum logic [2:0] {
    opNop      = 3'b000,
    opSetClock = 3'b001,
    opEnClock  = 3'b010,
    opSetAlarm = 3'b101,
    opSetTimer = 3'b110,
    opEnAlarm  = 3'b111
  } opcodeT;

  // clock rates relative to clk_1x
  typedef enum logic [1:0] {
    rateFull    = 2'b00,
    rateHalf    = 2'b01,
    rateQuarter = 2'b10,
    rateStop    = 2'b11
  } rateT;

  // per client status bit
  typedef enum logic {
    nack = 1'b0,
    ack  = 1'b1
  } statusT;

  typedef logic [`TMR_COUNT_W-1:0]   countT;
  typedef logic [`TMR_CLK_IDX_W-1:0] clkIdxT;
  typedef logic [`TMR_ALM_IDX_W-1:0] almIdxT;
  typedef logic [2*`TMR_HALF_W-1:0]  cmdWordT;   // upper half : lower half

endpackage

// File: design/timer_cfg.svh
//////////////////////////////////////////////////////////////////////
// timer block configuration
// sizes, instruction field positions and alarm hit hold length
//////////////////////////////////////////////////////////////////////
`ifndef TIMER_CFG_SVH
`define TIMER_CFG_SVH

// sizes
`define TMR_COUNT_W      16       // clock count and alarm value
`define TMR_NUM_CLOCKS   16
`define TMR_NUM_ALARMS   24
`define TMR_CLK_IDX_W    4
`define TMR_ALM_IDX_W    5        // 24..31 reachable, rejected by arbiter
`define TMR_HALF_W       16       // one instruction half per cycle

// 32-bit instruction fields
`define TMR_F_OPCODE     31:29
`define TMR_F_CLOCK      28:25    // clock commands
`define TMR_F_ALARM      28:24    // alarm class commands
`define TMR_F_RATE       23:22
`define TMR_F_ENABLE     23       // enable bit, or repeat for set alarm
`define TMR_F_ASSIGN     19:16    // clock an alarm is compared against
`define TMR_F_VALUE      15:0

// alarm hit output
`define TMR_HOLD_CYCLES  2        // cycles each hit stays visible

`endif
